// File: design/ntps_pkg.sv
package ntps_pkg;

  // ------------------------------
  // Bus and datapath widths
  // ------------------------------
  localparam int ADDR_W        = 16;
  localparam int DATA_W        = 32;
  localparam int NUM_PORTS     = 4;
  localparam int TIME_W        = 64;
  localparam int XPHY_STATUS_W = 5;
  localparam int XPHY_CONFIG_W = 3;

  // Slot number above a 4 KiB byte window
  localparam int SLOT_LSB = 12;
  localparam int SLOT_W   = ADDR_W - SLOT_LSB;
  localparam int OFS_W    = SLOT_LSB;
  localparam int IDX_W    = OFS_W - 2;

  // ------------------------------
  // Slot map
  // ------------------------------
  localparam int SLOT_NTPA    = 0;
  localparam int SLOT_NTPB    = 1;
  localparam int SLOT_ETHLITE = 2;
  localparam int SLOT_NP0     = 3;
  localparam int SLOT_PVT     = 7;
  // Key slots, never decoded
  localparam int SLOT_KEY0    = 8;
  localparam int SLOT_KEY3    = 11;

  // ------------------------------
  // Register word indices
  // ------------------------------
  localparam int REG_GEN_CONFIG  = 0;
  localparam int REG_NTP_CONFIG  = 1;
  localparam int REG_NTP_REF_ID  = 2;
  localparam int REG_NTP_RX_OFS  = 3;
  localparam int REG_NTP_TX_OFS  = 4;
  localparam int REG_PP_STATUS   = 5;
  localparam int REG_PORT_STATUS = 6;
  localparam int REG_LAST        = 6;

  // Position of sync-ok inside the port status word
  localparam int SYNC_OK_BIT = 8;

  typedef struct packed {
    logic [XPHY_CONFIG_W-1:0] xphy_config;
    logic [3:0]               reserved_hi;
    logic                     clock_select;
    logic [23:0]              reserved_lo;
  } gen_config_fields_t;

  // Raw bus word, or the same word split into fields
  typedef union packed {
    logic [DATA_W-1:0]  raw;
    gen_config_fields_t f;
  } gen_config_t;

endpackage

// File: design/apb_slot_if.sv
`timescale 1ns/10ps

// One APB slot between the decoder and a register bank
interface apb_slot_if import ntps_pkg::*; ();

  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [OFS_W-1:0]  paddr;
  logic [DATA_W-1:0] pwdata;
  logic [DATA_W-1:0] prdata;
  logic              pslverr;

  modport decoder (
    output psel, penable, pwrite, paddr, pwdata,
    input  prdata, pslverr
  );

  modport bank (
    input  psel, penable, pwrite, paddr, pwdata,
    output prdata, pslverr
  );

endinterface

// File: design/apb_slot_decoder.sv
`timescale 1ns/10ps

module apb_slot_decoder import ntps_pkg::*; (
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [ADDR_W-1:0] paddr,
  input  logic [DATA_W-1:0] pwdata,
  output logic [DATA_W-1:0] prdata,
  output logic              pslverr,
  apb_slot_if.decoder       np [NUM_PORTS]
);

  logic [SLOT_W-1:0]    slot;
  logic [NUM_PORTS-1:0] slot_hit;
  logic [DATA_W-1:0]    slot_rdata [NUM_PORTS];
  logic [NUM_PORTS-1:0] slot_err;
  logic                 access;

  assign slot   = paddr[ADDR_W-1:SLOT_LSB];
  assign access = psel & penable;

  // ------------------------------
  // Fan-out toward the banks
  // ------------------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_slot
    assign slot_hit[i] = (slot == SLOT_W'(SLOT_NP0 + i));

    // Only the addressed bank sees psel
    assign np[i].psel    = psel & slot_hit[i];
    assign np[i].penable = penable;
    assign np[i].pwrite  = pwrite;
    assign np[i].paddr   = paddr[OFS_W-1:0];
    assign np[i].pwdata  = pwdata;

    assign slot_rdata[i] = np[i].prdata;
    assign slot_err[i]   = np[i].pslverr;
  end

  // ------------------------------
  // Response merge
  // ------------------------------
  always_comb begin
    prdata  = '0;
    pslverr = 1'b0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (slot_hit[i]) begin
        prdata  = slot_rdata[i];
        pslverr = slot_err[i];
      end
    end

    // NTP clocks, Ethernet-lite, monitor, key slots and above
    if (access && (slot_hit == '0)) begin
      prdata  = '0;
      pslverr = 1'b1;
    end
  end

endmodule

// File: design/network_path_regs.sv
`timescale 1ns/10ps

module network_path_regs import ntps_pkg::*; (
  input  logic                     clk156,
  input  logic                     reset,
  apb_slot_if.bank                 bus,
  input  logic [DATA_W-1:0]        pp_status,
  input  logic [XPHY_STATUS_W-1:0] xphy_status,
  input  logic                     ntp_sync_ok,
  output gen_config_t              gen_config,
  output logic [DATA_W-1:0]        ntp_config,
  output logic [DATA_W-1:0]        ntp_ref_id,
  output logic [DATA_W-1:0]        ntp_rx_ofs,
  output logic [DATA_W-1:0]        ntp_tx_ofs,
  output logic [XPHY_CONFIG_W-1:0] xphy_config
);

  logic [IDX_W-1:0]  reg_idx;
  logic              access;
  logic              idx_valid;
  logic              idx_ro;
  logic              bus_err;
  logic              wr_en;
  logic [DATA_W-1:0] port_status;
  logic [DATA_W-1:0] rd_word;

  // Word index with byte lanes ignored
  assign reg_idx = bus.paddr[OFS_W-1:2];
  assign access  = bus.psel & bus.penable;

  // ------------------------------
  // Access checks
  // ------------------------------
  assign idx_valid = (reg_idx <= IDX_W'(REG_LAST));
  assign idx_ro    = (reg_idx == IDX_W'(REG_PP_STATUS)) ||
                     (reg_idx == IDX_W'(REG_PORT_STATUS));
  assign bus_err   = access & (~idx_valid | (bus.pwrite & idx_ro));
  assign wr_en     = access & bus.pwrite & ~bus_err;

  // ------------------------------
  // Read/write registers
  // ------------------------------
  always_ff @(posedge clk156) begin
    if (reset) begin
      gen_config <= '0;
      ntp_config <= '0;
      ntp_ref_id <= '0;
      ntp_rx_ofs <= '0;
      ntp_tx_ofs <= '0;
    end else if (wr_en) begin
      case (reg_idx)
        IDX_W'(REG_GEN_CONFIG): gen_config.raw <= bus.pwdata;
        IDX_W'(REG_NTP_CONFIG): ntp_config     <= bus.pwdata;
        IDX_W'(REG_NTP_REF_ID): ntp_ref_id     <= bus.pwdata;
        IDX_W'(REG_NTP_RX_OFS): ntp_rx_ofs     <= bus.pwdata;
        IDX_W'(REG_NTP_TX_OFS): ntp_tx_ofs     <= bus.pwdata;
        default: ;
      endcase
    end
  end

  // PHY control straight from the general config word
  assign xphy_config = gen_config.f.xphy_config;

  // PHY status in the low bits and selected sync-ok above it
  always_comb begin
    port_status                      = '0;
    port_status[XPHY_STATUS_W-1:0]   = xphy_status;
    port_status[SYNC_OK_BIT]         = ntp_sync_ok;
  end

  // ------------------------------
  // Read path
  // ------------------------------
  always_comb begin
    case (reg_idx)
      IDX_W'(REG_GEN_CONFIG):  rd_word = gen_config.raw;
      IDX_W'(REG_NTP_CONFIG):  rd_word = ntp_config;
      IDX_W'(REG_NTP_REF_ID):  rd_word = ntp_ref_id;
      IDX_W'(REG_NTP_RX_OFS):  rd_word = ntp_rx_ofs;
      IDX_W'(REG_NTP_TX_OFS):  rd_word = ntp_tx_ofs;
      IDX_W'(REG_PP_STATUS):   rd_word = pp_status;
      IDX_W'(REG_PORT_STATUS): rd_word = port_status;
      default:                 rd_word = '0;
    endcase
  end

  // Data only on a read in the access cycle
  assign bus.prdata  = (access && !bus.pwrite) ? rd_word : '0;
  assign bus.pslverr = bus_err;

endmodule

// File: design/ntp_clock_select.sv
`timescale 1ns/10ps

module ntp_clock_select import ntps_pkg::*; (
  input  logic              clk156,
  input  logic              reset,
  input  logic              select,
  input  logic [TIME_W-1:0] ntp_time_a,
  input  logic              ntp_time_upd_a,
  input  logic              ntp_sync_ok_a,
  input  logic [TIME_W-1:0] ntp_time_b,
  input  logic              ntp_time_upd_b,
  input  logic              ntp_sync_ok_b,
  output logic [TIME_W-1:0] ntp_time,
  output logic              ntp_sync_ok
);

  logic [TIME_W-1:0] sel_time;
  logic              sel_upd;
  logic              sel_sync_ok;

  // Source b when select is set
  assign sel_time    = select ? ntp_time_b : ntp_time_a;
  assign sel_upd     = select ? ntp_time_upd_b : ntp_time_upd_a;
  assign sel_sync_ok = select ? ntp_sync_ok_b : ntp_sync_ok_a;

  always_ff @(posedge clk156) begin
    if (reset) begin
      ntp_time    <= '0;
      ntp_sync_ok <= 1'b0;
    end else begin
      ntp_sync_ok <= sel_sync_ok;
      // Time only moves on the selected source's update strobe
      if (sel_upd) begin
        ntp_time <= sel_time;
      end
    end
  end

endmodule

// File: design/ntps_interfaces.sv
`timescale 1ns/10ps

module ntps_interfaces import ntps_pkg::*; (
  input  logic                                    clk156,
  input  logic                                    reset,

  // Host register bus
  input  logic                                    psel,
  input  logic                                    penable,
  input  logic                                    pwrite,
  input  logic [ADDR_W-1:0]                       paddr,
  input  logic [DATA_W-1:0]                       pwdata,
  output logic [DATA_W-1:0]                       prdata,
  output logic                                    pslverr,

  // NTP time sources
  input  logic [TIME_W-1:0]                       ntp_time_a,
  input  logic                                    ntp_time_upd_a,
  input  logic                                    ntp_sync_ok_a,
  input  logic [TIME_W-1:0]                       ntp_time_b,
  input  logic                                    ntp_time_upd_b,
  input  logic                                    ntp_sync_ok_b,
  output logic [TIME_W-1:0]                       ntp_time,
  output logic                                    ntp_sync_ok,

  // Per-port status and configuration
  input  logic [NUM_PORTS-1:0][DATA_W-1:0]        pp_status,
  input  logic [NUM_PORTS-1:0][XPHY_STATUS_W-1:0] xphy_status,
  output gen_config_t [NUM_PORTS-1:0]             gen_config,
  output logic [NUM_PORTS-1:0][DATA_W-1:0]        ntp_config,
  output logic [NUM_PORTS-1:0][DATA_W-1:0]        ntp_ref_id,
  output logic [NUM_PORTS-1:0][DATA_W-1:0]        ntp_rx_ofs,
  output logic [NUM_PORTS-1:0][DATA_W-1:0]        ntp_tx_ofs,
  output logic [NUM_PORTS-1:0][XPHY_CONFIG_W-1:0] xphy_config
);

  apb_slot_if np_bus [NUM_PORTS] ();

  // ------------------------------
  // Slot decoder
  // ------------------------------
  apb_slot_decoder u_apb_slot_decoder (
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pslverr (pslverr),
    .np      (np_bus)
  );

  // ------------------------------
  // Network path banks
  // ------------------------------
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_np
    network_path_regs u_network_path_regs (
      .clk156      (clk156),
      .reset       (reset),
      .bus         (np_bus[i]),
      .pp_status   (pp_status[i]),
      .xphy_status (xphy_status[i]),
      .ntp_sync_ok (ntp_sync_ok),
      .gen_config  (gen_config[i]),
      .ntp_config  (ntp_config[i]),
      .ntp_ref_id  (ntp_ref_id[i]),
      .ntp_rx_ofs  (ntp_rx_ofs[i]),
      .ntp_tx_ofs  (ntp_tx_ofs[i]),
      .xphy_config (xphy_config[i])
    );
  end

  // ------------------------------
  // Time source select
  // ------------------------------
  // Port 0 config owns the choice for the whole board
  ntp_clock_select u_ntp_clock_select (
    .clk156         (clk156),
    .reset          (reset),
    .select         (gen_config[0].f.clock_select),
    .ntp_time_a     (ntp_time_a),
    .ntp_time_upd_a (ntp_time_upd_a),
    .ntp_sync_ok_a  (ntp_sync_ok_a),
    .ntp_time_b     (ntp_time_b),
    .ntp_time_upd_b (ntp_time_upd_b),
    .ntp_sync_ok_b  (ntp_sync_ok_b),
    .ntp_time       (ntp_time),
    .ntp_sync_ok    (ntp_sync_ok)
  );

endmodule

// File: sim/ntps_interfaces_sva.sv
`timescale 1ns/10ps

module ntps_interfaces_sva import ntps_pkg::*; (
  input logic                                    clk156,
  input logic                                    reset,
  input logic                                    psel,
  input logic                                    penable,
  input logic [DATA_W-1:0]                       prdata,
  input logic                                    pslverr,
  input logic                                    ntp_time_upd_a,
  input logic                                    ntp_time_upd_b,
  input logic [TIME_W-1:0]                       ntp_time,
  input logic                                    ntp_sync_ok,
  input gen_config_t [NUM_PORTS-1:0]             gen_config,
  input logic [NUM_PORTS-1:0][DATA_W-1:0]        ntp_config,
  input logic [NUM_PORTS-1:0][DATA_W-1:0]        ntp_ref_id,
  input logic [NUM_PORTS-1:0][DATA_W-1:0]        ntp_rx_ofs,
  input logic [NUM_PORTS-1:0][DATA_W-1:0]        ntp_tx_ofs,
  input logic [NUM_PORTS-1:0][XPHY_CONFIG_W-1:0] xphy_config
);

  logic sel_upd;

  // Update strobe of whichever source port 0 picks
  assign sel_upd = gen_config[0].f.clock_select ? ntp_time_upd_b : ntp_time_upd_a;

  assert property (@(posedge clk156) disable iff (reset)
    !(psel && penable) |-> (prdata == '0 && !pslverr))
    else $error("bus response outside the access cycle");

  assert property (@(posedge clk156) disable iff (reset)
    pslverr |-> (prdata == '0))
    else $error("error response carries read data");

  assert property (@(posedge clk156) disable iff (reset)
    (ntp_time != $past(ntp_time)) |-> $past(sel_upd))
    else $error("ntp_time moved without a selected update pulse");

  // First cycle out of reset
  assert property (@(posedge clk156)
    $fell(reset) |-> (ntp_time == '0 && !ntp_sync_ok && gen_config == '0 &&
                      ntp_config == '0 && ntp_ref_id == '0 && ntp_rx_ofs == '0 &&
                      ntp_tx_ofs == '0 && xphy_config == '0 && prdata == '0 && !pslverr))
    else $error("outputs not zero after reset");

endmodule

bind ntps_interfaces ntps_interfaces_sva u_ntps_interfaces_sva (
  .clk156         (clk156),
  .reset          (reset),
  .psel           (psel),
  .penable        (penable),
  .prdata         (prdata),
  .pslverr        (pslverr),
  .ntp_time_upd_a (ntp_time_upd_a),
  .ntp_time_upd_b (ntp_time_upd_b),
  .ntp_time       (ntp_time),
  .ntp_sync_ok    (ntp_sync_ok),
  .gen_config     (gen_config),
  .ntp_config     (ntp_config),
  .ntp_ref_id     (ntp_ref_id),
  .ntp_rx_ofs     (ntp_rx_ofs),
  .ntp_tx_ofs     (ntp_tx_ofs),
  .xphy_config    (xphy_config)
);

// File: sim/tb_ntps_interfaces.sv
`timescale 1ns/10ps

module tb_ntps_interfaces import ntps_pkg::*; ();

  localparam int NUM_RW_REGS     = 5;
  // Transfers issued by the main sequence
  localparam int PLANNED_XFERS   = 137;
  localparam int WATCHDOG_CYCLES = PLANNED_XFERS * 40 + 200;

  logic                                    clk156;
  logic                                    reset;
  logic                                    psel;
  logic                                    penable;
  logic                                    pwrite;
  logic [ADDR_W-1:0]                       paddr;
  logic [DATA_W-1:0]                       pwdata;
  logic [DATA_W-1:0]                       prdata;
  logic                                    pslverr;
  logic [TIME_W-1:0]                       ntp_time_a;
  logic                                    ntp_time_upd_a;
  logic                                    ntp_sync_ok_a;
  logic [TIME_W-1:0]                       ntp_time_b;
  logic                                    ntp_time_upd_b;
  logic                                    ntp_sync_ok_b;
  logic [TIME_W-1:0]                       ntp_time;
  logic                                    ntp_sync_ok;
  logic [NUM_PORTS-1:0][DATA_W-1:0]        pp_status;
  logic [NUM_PORTS-1:0][XPHY_STATUS_W-1:0] xphy_status;
  gen_config_t [NUM_PORTS-1:0]             gen_config;
  logic [NUM_PORTS-1:0][DATA_W-1:0]        ntp_config;
  logic [NUM_PORTS-1:0][DATA_W-1:0]        ntp_ref_id;
  logic [NUM_PORTS-1:0][DATA_W-1:0]        ntp_rx_ofs;
  logic [NUM_PORTS-1:0][DATA_W-1:0]        ntp_tx_ofs;
  logic [NUM_PORTS-1:0][XPHY_CONFIG_W-1:0] xphy_config;

  // Reference model state
  logic [DATA_W-1:0] exp_regs [NUM_PORTS][NUM_RW_REGS];
  logic [TIME_W-1:0] exp_time;
  logic              exp_sync_ok;
  logic              exp_sel;
  logic              exp_err;
  logic [DATA_W-1:0] exp_rdata;
  logic              src_en;

  ntps_interfaces u_ntps_interfaces (
    .clk156         (clk156),
    .reset          (reset),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pslverr        (pslverr),
    .ntp_time_a     (ntp_time_a),
    .ntp_time_upd_a (ntp_time_upd_a),
    .ntp_sync_ok_a  (ntp_sync_ok_a),
    .ntp_time_b     (ntp_time_b),
    .ntp_time_upd_b (ntp_time_upd_b),
    .ntp_sync_ok_b  (ntp_sync_ok_b),
    .ntp_time       (ntp_time),
    .ntp_sync_ok    (ntp_sync_ok),
    .pp_status      (pp_status),
    .xphy_status    (xphy_status),
    .gen_config     (gen_config),
    .ntp_config     (ntp_config),
    .ntp_ref_id     (ntp_ref_id),
    .ntp_rx_ofs     (ntp_rx_ofs),
    .ntp_tx_ofs     (ntp_tx_ofs),
    .xphy_config    (xphy_config)
  );

  initial begin
    clk156 = 1'b0;
    forever #4 clk156 = ~clk156;
  end

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t ns: %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1, "stopping at the first failed check");
  endtask

  // Response the register map calls for, error flag on top
  function automatic logic [DATA_W:0] expected_response(input logic wr, input int slot,
                                                        input int idx);
    int port;
    port = slot - SLOT_NP0;
    if (slot < SLOT_NP0 || slot >= SLOT_NP0 + NUM_PORTS) begin
      return {1'b1, {DATA_W{1'b0}}};
    end
    if (idx > REG_LAST || (wr && idx >= REG_PP_STATUS)) begin
      return {1'b1, {DATA_W{1'b0}}};
    end
    if (wr) begin
      return {1'b0, {DATA_W{1'b0}}};
    end
    if (idx == REG_PP_STATUS) begin
      return {1'b0, pp_status[port]};
    end
    if (idx == REG_PORT_STATUS) begin
      return {1'b0, 23'h0, exp_sync_ok, 3'h0, xphy_status[port]};
    end
    return {1'b0, exp_regs[port][idx]};
  endfunction

  // One APB transfer, entered and left on a falling edge
  task automatic apb_xfer(input logic wr, input int slot, input int idx,
                          input logic [DATA_W-1:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = {SLOT_W'(slot), IDX_W'(idx), 2'b00};
    pwdata  = data;
    @(negedge clk156);
    penable = 1'b1;
    {exp_err, exp_rdata} = expected_response(wr, slot, idx);
    @(negedge clk156);
    // Register took the word on the edge just passed
    if (wr && !exp_err) begin
      exp_regs[slot - SLOT_NP0][idx] = data;
    end
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic drive_status();
    for (int p = 0; p < NUM_PORTS; p++) begin
      pp_status[p]   = $urandom;
      xphy_status[p] = XPHY_STATUS_W'($urandom);
    end
  endtask

  // ------------------------------
  // Time source model
  // ------------------------------
  assign exp_sel = exp_regs[0][REG_GEN_CONFIG][24];

  always @(posedge clk156) begin
    if (reset) begin
      exp_time    <= '0;
      exp_sync_ok <= 1'b0;
    end else begin
      exp_sync_ok <= exp_sel ? ntp_sync_ok_b : ntp_sync_ok_a;
      if (exp_sel ? ntp_time_upd_b : ntp_time_upd_a) begin
        exp_time <= exp_sel ? ntp_time_b : ntp_time_a;
      end
    end
  end

  // ------------------------------
  // Checks against the model
  // ------------------------------
  assert property (@(posedge clk156) disable iff (reset)
    (psel && penable) |-> (pslverr == exp_err))
    else report_mismatch("pslverr differs in access cycle");
  assert property (@(posedge clk156) disable iff (reset)
    (psel && penable && !pwrite) |-> (prdata == exp_rdata))
    else report_mismatch("read data differs");
  assert property (@(posedge clk156) disable iff (reset) ntp_time == exp_time)
    else report_mismatch("ntp_time differs");
  assert property (@(posedge clk156) disable iff (reset) ntp_sync_ok == exp_sync_ok)
    else report_mismatch("ntp_sync_ok differs");

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port_chk
    assert property (@(posedge clk156) disable iff (reset)
      {gen_config[p].raw, ntp_config[p], ntp_ref_id[p], ntp_rx_ofs[p], ntp_tx_ofs[p]} ==
      {exp_regs[p][0], exp_regs[p][1], exp_regs[p][2], exp_regs[p][3], exp_regs[p][4]})
      else report_mismatch($sformatf("port %0d register outputs differ", p));
    assert property (@(posedge clk156) disable iff (reset)
      xphy_config[p] == exp_regs[p][REG_GEN_CONFIG][31:29])
      else report_mismatch($sformatf("port %0d xphy_config differs", p));
  end

  // Randomized NTP sources once enabled
  initial begin
    wait (src_en);
    forever begin
      @(negedge clk156);
      ntp_time_a     = {$urandom, $urandom};
      ntp_time_upd_a = ($urandom_range(3) == 0);
      ntp_sync_ok_a  = ($urandom_range(1) == 0);
      ntp_time_b     = {$urandom, $urandom};
      ntp_time_upd_b = ($urandom_range(3) == 0);
      ntp_sync_ok_b  = ($urandom_range(1) == 0);
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk156);
    $display("timeout: test sequence still running after %0d cycles", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    void'($urandom(32'hfb80_f56d));
    reset          = 1'b1;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    ntp_time_a     = '0;
    ntp_time_upd_a = 1'b0;
    ntp_sync_ok_a  = 1'b0;
    ntp_time_b     = '0;
    ntp_time_upd_b = 1'b0;
    ntp_sync_ok_b  = 1'b0;
    pp_status      = '0;
    xphy_status    = '0;
    src_en         = 1'b0;
    exp_err        = 1'b0;
    exp_rdata      = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int r = 0; r < NUM_RW_REGS; r++) begin
        exp_regs[p][r] = '0;
      end
    end
    repeat (2) @(negedge clk156);
    reset = 1'b0;

    // Everything reads back zero after reset
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int r = 0; r <= REG_LAST; r++) begin
        apb_xfer(1'b0, SLOT_NP0 + p, r, '0);
      end
    end

    drive_status();
    src_en = 1'b1;

    // Write and read back each RW register, port 0 stays on source a
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int r = 0; r < NUM_RW_REGS; r++) begin
        logic [DATA_W-1:0] data;
        data = $urandom;
        if (p == 0 && r == REG_GEN_CONFIG) begin
          data[24] = 1'b0;
        end
        apb_xfer(1'b1, SLOT_NP0 + p, r, data);
        apb_xfer(1'b0, SLOT_NP0 + p, r, '0);
      end
    end

    // Unmapped slots
    for (int s = 0; s < 16; s++) begin
      if (s < SLOT_NP0 || s >= SLOT_NP0 + NUM_PORTS) begin
        apb_xfer(1'b0, s, REG_GEN_CONFIG, '0);
        apb_xfer(1'b1, s, REG_GEN_CONFIG, $urandom);
      end
    end

    // Bad indices and read-only writes
    for (int p = 0; p < NUM_PORTS; p++) begin
      apb_xfer(1'b0, SLOT_NP0 + p, 7, '0);
      apb_xfer(1'b1, SLOT_NP0 + p, 7, $urandom);
      apb_xfer(1'b0, SLOT_NP0 + p, 8, '0);
      apb_xfer(1'b1, SLOT_NP0 + p, 8, $urandom);
      apb_xfer(1'b0, SLOT_NP0 + p, 1023, '0);
      apb_xfer(1'b1, SLOT_NP0 + p, 1023, $urandom);
      apb_xfer(1'b1, SLOT_NP0 + p, REG_PP_STATUS, $urandom);
      apb_xfer(1'b1, SLOT_NP0 + p, REG_PORT_STATUS, $urandom);
    end

    drive_status();
    for (int p = 0; p < NUM_PORTS; p++) begin
      apb_xfer(1'b0, SLOT_NP0 + p, REG_PP_STATUS, '0);
      apb_xfer(1'b0, SLOT_NP0 + p, REG_PORT_STATUS, '0);
    end

    // Source a for a while, then switch to b
    repeat (60) @(negedge clk156);
    apb_xfer(1'b1, SLOT_NP0, REG_GEN_CONFIG, $urandom | 32'h0100_0000);
    repeat (60) @(negedge clk156);
    for (int p = 0; p < NUM_PORTS; p++) begin
      apb_xfer(1'b0, SLOT_NP0 + p, REG_PORT_STATUS, '0);
    end

    repeat (4) @(negedge clk156);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: sim.f
design/ntps_pkg.sv
design/apb_slot_if.sv
design/apb_slot_decoder.sv
design/network_path_regs.sv
design/ntp_clock_select.sv
design/ntps_interfaces.sv
sim/ntps_interfaces_sva.sv
sim/tb_ntps_interfaces.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the NTP server interface testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_ntps_interfaces \
  -f sim.f \
  -o Vtb_ntps_interfaces
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_ntps_interfaces 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "ALL CHECKS PASSED"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi
